// ==== sources.f ====
logic/dbg_apb_pkg.sv
logic/dbg_core_pkg.sv
logic/dbg_apb_bus.sv
logic/core_dbg_apb.sv
logic/core_dbg_regs.sv
logic/dbg_subsystem.sv
test/tb_dbg_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the debug subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module tb_dbg_subsystem -o tb_sim

./obj_dir/tb_sim > sim.log
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation did not pass, see sim.log"
exit 1

// ==== test/tb_dbg_subsystem.sv ====
module tb_dbg_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] id_base = 32'hdb60_0000;  // identification word of core 0
    localparam int timeout_cycles = 10;
    localparam int nr_random = 16;

    logic                               clk;
    logic                               reset;
    logic [dbg_apb_pkg::ADDR_WIDTH-1:0] paddr;
    logic                               psel;
    logic                               penable;
    logic                               pwrite;
    logic [dbg_apb_pkg::DATA_WIDTH-1:0] pwdata;
    logic [dbg_apb_pkg::STRB_WIDTH-1:0] pstrb;
    logic                               pready;
    logic [dbg_apb_pkg::DATA_WIDTH-1:0] prdata;
    logic                               pslverr;

    // stimulus table held as parallel queues with one element per entry
    string       tbl_name[$];
    logic        tbl_write[$];
    logic [7:0]  tbl_addr[$];
    logic [31:0] tbl_wdata[$];
    logic [3:0]  tbl_strb[$];
    logic [31:0] tbl_rdata[$];
    logic        tbl_err[$];
    logic        tbl_from_model[$];  // expected read data comes from the mirror

    logic [31:0] mirror [2][32];  // expected contents of both register files

    int value_errs;
    int timeout_errs;

    dbg_subsystem UUT (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .pstrb   (pstrb),
        .pready  (pready),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    always #2 clk = ~clk;

    function automatic logic [7:0] word_addr(input int core, input int idx, input int low);
        return 8'((core << 7) | (idx << 2) | (low & 3));
    endfunction

    // byte lanes with a set strobe take the new data
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_data,
                                                input logic [31:0] new_data,
                                                input logic [3:0]  strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_data & ~mask) | (new_data & mask);
    endfunction

    task automatic add_entry(input string name, input logic wr, input logic [7:0] addr,
                             input logic [31:0] wdata, input logic [3:0] strb,
                             input logic [31:0] rdata, input logic err,
                             input logic from_model);
        tbl_name.push_back(name);
        tbl_write.push_back(wr);
        tbl_addr.push_back(addr);
        tbl_wdata.push_back(wdata);
        tbl_strb.push_back(strb);
        tbl_rdata.push_back(rdata);
        tbl_err.push_back(err);
        tbl_from_model.push_back(from_model);
    endtask

    // one APB transfer made of a setup cycle and access cycles until pready
    task automatic apb_transfer(input string name, input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata, input logic [3:0] strb,
                                output logic [31:0] rdata, output logic err,
                                output int cycles, output logic timed_out);
        rdata     = '0;
        err       = 1'b0;
        cycles    = 0;
        timed_out = 1'b0;
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        pstrb   = wr ? strb : 4'b0000;  // APB4 reads carry no strobes
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 1;
        #1;  // outputs settled, well before the next rising edge
        while (!pready) begin
            if (cycles >= timeout_cycles) begin
                timed_out = 1'b1;
                break;
            end
            @(negedge clk);
            cycles++;
            #1;
        end
        if (timed_out) begin
            $display("timeout: no pready within %0d cycles on %s", timeout_cycles, name);
        end else begin
            rdata = prdata;
            err   = pslverr;
        end
        @(negedge clk);  // the transfer completed at the rising edge just passed
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic build_table();
        int core;
        int idx;
        logic [31:0] data;
        logic [3:0] strb;
        logic [7:0] rnd_addr[$];
        // contents after reset
        for (int c = 0; c < 2; c++) begin
            for (int w = 0; w < 32; w++) begin
                add_entry($sformatf("reset_c%0d_w%0d", c, w), 1'b0, word_addr(c, w, 0), '0,
                          4'h0, (w == 0) ? id_base + 32'(c) : 32'h0, 1'b0, 1'b0);
            end
        end
        // same word index on both cores
        add_entry("full_wr_c0", 1'b1, word_addr(0, 5, 0), 32'hcafe_0005, 4'hf, '0, 1'b0, 1'b0);
        add_entry("full_wr_c1", 1'b1, word_addr(1, 5, 0), 32'h5a5a_1105, 4'hf, '0, 1'b0, 1'b0);
        add_entry("full_rd_c0", 1'b0, word_addr(0, 5, 0), '0, 4'h0, 32'hcafe_0005, 1'b0, 1'b0);
        add_entry("full_rd_c1", 1'b0, word_addr(1, 5, 0), '0, 4'h0, 32'h5a5a_1105, 1'b0, 1'b0);
        // partial strobes
        add_entry("part_base", 1'b1, word_addr(0, 7, 0), 32'h1122_3344, 4'hf, '0, 1'b0, 1'b0);
        add_entry("part_wr", 1'b1, word_addr(0, 7, 0), 32'haabb_ccdd, 4'b0101, '0, 1'b0, 1'b0);
        add_entry("part_rd", 1'b0, word_addr(0, 7, 0), '0, 4'h0, '0, 1'b0, 1'b1);
        add_entry("part_rd_lit", 1'b0, word_addr(0, 7, 0), '0, 4'h0, 32'h11bb_33dd, 1'b0, 1'b0);
        add_entry("part_wr_hi", 1'b1, word_addr(1, 31, 0), 32'hf00d_beef, 4'b1000, '0, 1'b0, 1'b0);
        add_entry("part_rd_hi", 1'b0, word_addr(1, 31, 0), '0, 4'h0, '0, 1'b0, 1'b1);
        // identification word is read-only
        add_entry("id_wr_c0", 1'b1, word_addr(0, 0, 0), 32'hffff_ffff, 4'hf, '0, 1'b1, 1'b0);
        add_entry("id_rd_c0", 1'b0, word_addr(0, 0, 0), '0, 4'h0, id_base, 1'b0, 1'b0);
        add_entry("id_wr_c1", 1'b1, word_addr(1, 0, 0), 32'h0000_0000, 4'h3, '0, 1'b1, 1'b0);
        add_entry("id_rd_c1", 1'b0, word_addr(1, 0, 0), '0, 4'h0, id_base + 32'h1, 1'b0, 1'b0);
        // random writes followed by a read of every written word
        for (int n = 0; n < nr_random; n++) begin
            core = int'($urandom % 2);
            idx  = 1 + int'($urandom % 31);
            data = $urandom;
            strb = 4'($urandom % 16);
            rnd_addr.push_back(word_addr(core, idx, int'($urandom % 4)));  // low bits ignored
            add_entry($sformatf("rnd_wr_%0d", n), 1'b1, rnd_addr[n], data, strb, '0, 1'b0, 1'b0);
        end
        for (int n = 0; n < nr_random; n++) begin
            add_entry($sformatf("rnd_rd_%0d", n), 1'b0, rnd_addr[n], '0, 4'h0, '0, 1'b0, 1'b1);
        end
    endtask

    initial begin
        logic [31:0] exp_rdata;
        logic [31:0] act_rdata;
        logic        act_err;
        logic        timed_out;
        int          cycles;
        int          exp_cycles;
        int          core;
        int          idx;

        clk          = 1'b0;
        reset        = 1'b1;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        pstrb        = '0;
        value_errs   = 0;
        timeout_errs = 0;
        void'($urandom(32'h4f3d_858d));

        for (int c = 0; c < 2; c++) begin
            for (int w = 0; w < 32; w++) begin
                mirror[c][w] = (w == 0) ? id_base + 32'(c) : 32'h0;
            end
        end
        build_table();

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < tbl_name.size(); i++) begin
            core      = int'(tbl_addr[i][7]);
            idx       = int'(tbl_addr[i][6:2]);
            exp_rdata = tbl_from_model[i] ? mirror[core][idx] : tbl_rdata[i];
            exp_cycles = tbl_write[i] ? 1 : 2;  // reads wait one extra access cycle
            apb_transfer(tbl_name[i], tbl_write[i], tbl_addr[i], tbl_wdata[i], tbl_strb[i],
                         act_rdata, act_err, cycles, timed_out);
            if (timed_out) begin
                timeout_errs++;
            end else begin
                if (cycles != exp_cycles) begin
                    $display("ERR %s access cycles expected %0d actual %0d",
                             tbl_name[i], exp_cycles, cycles);
                    value_errs++;
                end
                if (act_err !== tbl_err[i]) begin
                    $display("ERR %s pslverr expected %b actual %b",
                             tbl_name[i], tbl_err[i], act_err);
                    value_errs++;
                end
                if (!tbl_write[i] && act_rdata !== exp_rdata) begin
                    $display("ERR %s prdata expected %h actual %h",
                             tbl_name[i], exp_rdata, act_rdata);
                    value_errs++;
                end
            end
            if (tbl_write[i] && idx != 0) begin
                mirror[core][idx] = merge_bytes(mirror[core][idx], tbl_wdata[i], tbl_strb[i]);
            end
        end

        $display("%0d entries, value errors: %0d, timeouts: %0d",
                 tbl_name.size(), value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/dbg_subsystem.sv ====
module dbg_subsystem (
    input  logic                               clk,
    input  logic                               reset,

    input  logic [dbg_apb_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [dbg_apb_pkg::DATA_WIDTH-1:0] pwdata,
    input  logic [dbg_apb_pkg::STRB_WIDTH-1:0] pstrb,
    output logic                               pready,
    output logic [dbg_apb_pkg::DATA_WIDTH-1:0] prdata,
    output logic                               pslverr
);

    logic [dbg_apb_pkg::NR_CORES-1:0]   core_psel;
    logic [dbg_apb_pkg::NR_CORES-1:0]   core_pready;
    logic [dbg_apb_pkg::DATA_WIDTH-1:0] core_prdata [dbg_apb_pkg::NR_CORES];
    logic [dbg_apb_pkg::NR_CORES-1:0]   core_pslverr;

    dbg_apb_bus u_bus (
        .paddr        (paddr),
        .psel         (psel),
        .core_psel    (core_psel),
        .core_pready  (core_pready),
        .core_prdata  (core_prdata),
        .core_pslverr (core_pslverr),
        .pready       (pready),
        .prdata       (prdata),
        .pslverr      (pslverr)
    );

    for (genvar i = 0; i < dbg_apb_pkg::NR_CORES; i++) begin : g_core
        logic                                     dbg_req;
        dbg_core_pkg::dbg_op_t                    dbg_op;
        logic [dbg_core_pkg::REG_INDEX_WIDTH-1:0] dbg_index;
        logic [dbg_apb_pkg::DATA_WIDTH-1:0]       dbg_wdata;
        logic [dbg_apb_pkg::STRB_WIDTH-1:0]       dbg_wstrb;
        logic                                     dbg_done;
        logic [dbg_apb_pkg::DATA_WIDTH-1:0]       dbg_rdata;
        logic                                     dbg_err;

        core_dbg_apb u_dap (
            .clk       (clk),
            .reset     (reset),
            .psel      (core_psel[i]),
            .penable   (penable),
            .pwrite    (pwrite),
            .pwdata    (pwdata),
            .pstrb     (pstrb),
            .pindex    (paddr[dbg_core_pkg::REG_INDEX_WIDTH+1:2]),  // word index
            .pready    (core_pready[i]),
            .prdata    (core_prdata[i]),
            .pslverr   (core_pslverr[i]),
            .dbg_req   (dbg_req),
            .dbg_op    (dbg_op),
            .dbg_index (dbg_index),
            .dbg_wdata (dbg_wdata),
            .dbg_wstrb (dbg_wstrb),
            .dbg_done  (dbg_done),
            .dbg_rdata (dbg_rdata),
            .dbg_err   (dbg_err)
        );

        core_dbg_regs #(
            .core_index (i)
        ) u_regs (
            .clk       (clk),
            .reset     (reset),
            .dbg_req   (dbg_req),
            .dbg_op    (dbg_op),
            .dbg_index (dbg_index),
            .dbg_wdata (dbg_wdata),
            .dbg_wstrb (dbg_wstrb),
            .dbg_done  (dbg_done),
            .dbg_rdata (dbg_rdata),
            .dbg_err   (dbg_err)
        );
    end

endmodule

// ==== logic/core_dbg_regs.sv ====
module core_dbg_regs #(
    parameter int unsigned core_index = 0
) (
    input  logic                                   clk,
    input  logic                                   reset,

    input  logic                                   dbg_req,
    input  dbg_core_pkg::dbg_op_t                  dbg_op,
    input  logic [dbg_core_pkg::REG_INDEX_WIDTH-1:0] dbg_index,
    input  logic [dbg_apb_pkg::DATA_WIDTH-1:0]     dbg_wdata,
    input  logic [dbg_apb_pkg::STRB_WIDTH-1:0]     dbg_wstrb,
    output logic                                   dbg_done,
    output logic [dbg_apb_pkg::DATA_WIDTH-1:0]     dbg_rdata,
    output logic                                   dbg_err
);

    logic [dbg_apb_pkg::DATA_WIDTH-1:0] regs [dbg_core_pkg::NR_DBG_REGS];

    logic                               id_hit;    // index points at the id word
    logic                               wr_req;    // write request this cycle
    logic                               rd_req;    // read request this cycle
    logic [dbg_apb_pkg::DATA_WIDTH-1:0] id_word;   // identification value
    logic                               rd_done_q; // read result valid
    logic [dbg_apb_pkg::DATA_WIDTH-1:0] rd_data_q;

    assign id_hit  = (dbg_index == dbg_core_pkg::ID_REG_INDEX);
    assign wr_req  = dbg_req && (dbg_op == dbg_core_pkg::dbg_write);
    assign rd_req  = dbg_req && (dbg_op == dbg_core_pkg::dbg_read);
    assign id_word = dbg_core_pkg::CORE_ID_BASE + core_index;

    // strobed write, the id word is never touched
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < dbg_core_pkg::NR_DBG_REGS; w++) begin
                regs[w] <= '0;
            end
        end else if (wr_req && !id_hit) begin
            for (int b = 0; b < dbg_apb_pkg::STRB_WIDTH; b++) begin
                if (dbg_wstrb[b]) begin
                    regs[dbg_index][8*b +: 8] <= dbg_wdata[8*b +: 8];
                end
            end
        end
    end

    // read path, one cycle behind the request
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_done_q <= 1'b0;
        end else begin
            rd_done_q <= rd_req;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_data_q <= id_hit ? id_word : regs[dbg_index];
        end
    end

    // A write completes in its own request cycle. The error flag only
    // ever comes from a write aimed at the id word, reads never fail.
    assign dbg_done  = wr_req || rd_done_q;
    assign dbg_err   = wr_req && id_hit;
    assign dbg_rdata = rd_data_q;

endmodule

// ==== logic/core_dbg_apb.sv ====
module core_dbg_apb (
    input  logic                                   clk,
    input  logic                                   reset,

    // APB4 completer side
    input  logic                                   psel,
    input  logic                                   penable,
    input  logic                                   pwrite,
    input  logic [dbg_apb_pkg::DATA_WIDTH-1:0]     pwdata,
    input  logic [dbg_apb_pkg::STRB_WIDTH-1:0]     pstrb,
    input  logic [dbg_core_pkg::REG_INDEX_WIDTH-1:0] pindex,
    output logic                                   pready,
    output logic [dbg_apb_pkg::DATA_WIDTH-1:0]     prdata,
    output logic                                   pslverr,

    // debug request towards the register file
    output logic                                   dbg_req,
    output dbg_core_pkg::dbg_op_t                  dbg_op,
    output logic [dbg_core_pkg::REG_INDEX_WIDTH-1:0] dbg_index,
    output logic [dbg_apb_pkg::DATA_WIDTH-1:0]     dbg_wdata,
    output logic [dbg_apb_pkg::STRB_WIDTH-1:0]     dbg_wstrb,
    input  logic                                   dbg_done,
    input  logic [dbg_apb_pkg::DATA_WIDTH-1:0]     dbg_rdata,
    input  logic                                   dbg_err
);

    dbg_apb_pkg::apb_state_t state;
    dbg_apb_pkg::apb_state_t state_next;

    logic setup;     // psel high, penable low
    logic access;    // psel and penable both high
    logic busy;      // a transfer is in flight on this port

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign busy   = (state != dbg_apb_pkg::st_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dbg_apb_pkg::st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Only st_access can raise dbg_req, and it leaves that state in
    // the same cycle, so one transfer gives exactly one request.
    always_comb begin
        state_next = state;
        dbg_req    = 1'b0;
        case (state)
            dbg_apb_pkg::st_idle: begin
                if (setup) begin
                    state_next = dbg_apb_pkg::st_access;
                end
            end
            dbg_apb_pkg::st_access: begin
                if (access) begin
                    dbg_req    = 1'b1;
                    state_next = dbg_done ? dbg_apb_pkg::st_idle : dbg_apb_pkg::st_wait;
                end else if (!psel) begin
                    state_next = dbg_apb_pkg::st_idle;  // requester walked away
                end
            end
            dbg_apb_pkg::st_wait: begin
                if (dbg_done || !psel) begin
                    state_next = dbg_apb_pkg::st_idle;
                end
            end
            default: begin
                state_next = dbg_apb_pkg::st_idle;
            end
        endcase
    end

    // request payload straight from the APB inputs, held stable by the requester
    assign dbg_op    = pwrite ? dbg_core_pkg::dbg_write : dbg_core_pkg::dbg_read;
    assign dbg_index = pindex;
    assign dbg_wdata = pwdata;
    assign dbg_wstrb = pwrite ? pstrb : '0;  // no strobes on a read

    // completion mirrors the register file, no latency guessed here
    assign pready  = busy && dbg_done;
    assign prdata  = (pready && !pwrite) ? dbg_rdata : '0;
    assign pslverr = pready && dbg_err;

endmodule

// ==== logic/dbg_apb_bus.sv ====
module dbg_apb_bus (
    input  logic [dbg_apb_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic                               psel,

    // per-core select towards the access ports
    output logic [dbg_apb_pkg::NR_CORES-1:0]   core_psel,

    // per-core responses coming back
    input  logic [dbg_apb_pkg::NR_CORES-1:0]   core_pready,
    input  logic [dbg_apb_pkg::DATA_WIDTH-1:0] core_prdata [dbg_apb_pkg::NR_CORES],
    input  logic [dbg_apb_pkg::NR_CORES-1:0]   core_pslverr,

    // response seen by the requester
    output logic                               pready,
    output logic [dbg_apb_pkg::DATA_WIDTH-1:0] prdata,
    output logic                               pslverr
);

    logic core_sel;  // core picked by the current address

    assign core_sel = paddr[dbg_apb_pkg::CORE_SEL_BIT];

    // one-hot select, only the addressed core sees psel
    always_comb begin
        core_psel = '0;
        for (int i = 0; i < dbg_apb_pkg::NR_CORES; i++) begin
            core_psel[i] = psel && (int'(core_sel) == i);
        end
    end

    // Response collection. The select is one-hot, so an AND-OR merge
    // acts as the mux. With psel low nothing is selected and the
    // requester sees pready low, prdata zero and pslverr low.
    always_comb begin
        pready  = 1'b0;
        prdata  = '0;
        pslverr = 1'b0;
        for (int i = 0; i < dbg_apb_pkg::NR_CORES; i++) begin
            if (core_psel[i]) begin
                pready  = pready | core_pready[i];
                prdata  = prdata | core_prdata[i];
                pslverr = pslverr | core_pslverr[i];
            end
        end
    end

endmodule

// ==== logic/dbg_core_pkg.sv ====
package dbg_core_pkg;

    // register map of one core's debug register file
    localparam int REG_INDEX_WIDTH = 5;   // word index width
    localparam int NR_DBG_REGS     = 32;  // words per core
    localparam int ID_REG_INDEX    = 0;   // read-only identification word

    // identification word reads as base plus core number
    localparam logic [31:0] CORE_ID_BASE = 32'hdb60_0000;

    // operation carried by a debug request
    typedef enum logic {
        dbg_read,   // fetch one word
        dbg_write   // strobed update of one word
    } dbg_op_t;

endpackage

// ==== logic/dbg_apb_pkg.sv ====
package dbg_apb_pkg;

    // requester side of the debug bus
    localparam int ADDR_WIDTH   = 8;   // byte address, bits 1:0 ignored
    localparam int DATA_WIDTH   = 32;  // pwdata, prdata and debug data
    localparam int STRB_WIDTH   = 4;   // one strobe per byte lane
    localparam int NR_CORES     = 2;   // cores hanging off the bus
    localparam int CORE_SEL_BIT = 7;   // paddr bit that picks the core

    // word index lives in paddr[6:2], below the core select bit

    // completer FSM of each access port
    typedef enum logic [1:0] {
        st_idle,    // waiting for a setup cycle
        st_access,  // first access cycle, debug request goes out
        st_wait     // request issued, waiting for its completion
    } apb_state_t;

endpackage
